/* src/lsu_params.svh */
// Width defines for the load/store unit
// Address, data bus and byte strobe widths, fixed by the ISA

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Byte address of a data access
`define LSU_ADDR_W 64

// Doubleword data bus
`define LSU_DATA_W 64

// One strobe bit per data byte
`define LSU_STRB_W 8

`endif

/* src/lsu_pkg.sv */
// Shared types for the load/store unit
// Memory operation codes, issue FSM states, address and data types

`default_nettype none

package lsu_pkg;

`include "lsu_params.svh"

    // Load and store opcodes, signed loads first
    typedef enum logic [3:0] {
        LB,
        LH,
        LW,
        LD,
        LBU,
        LHU,
        LWU,
        SB,
        SH,
        SW,
        SD
    } mem_op_e;

    typedef enum logic {
        ISSUE_IDLE,                 // Waiting for a command
        ISSUE_BUSY                  // One access in flight
    } issue_state_e;

    typedef logic [`LSU_ADDR_W-1:0] lsu_addr_t;
    typedef logic [`LSU_DATA_W-1:0] lsu_data_t;

endpackage

`default_nettype wire

/* src/lsu_req_if.sv */
// Decoded access from the issue stage to the access block
// Modports for the issue side, the access side and a read-only monitor

`timescale 1ns/1ns
`default_nettype none

interface lsu_req_if import lsu_pkg::*; ();

    logic      new_instr;           // First cycle of a new access
    logic      valid;               // Access fields are valid
    lsu_addr_t addr;                // Effective byte address
    lsu_data_t wdata;               // Store data, low aligned
    logic      load;
    logic      store;
    logic      d_double;
    logic      d_word;
    logic      d_half;
    logic      d_byte;
    logic      sext;                // Sign extend load data
    logic      ready;               // Access done this cycle

    modport issue (
        output new_instr, valid, addr, wdata, load, store,
        output d_double, d_word, d_half, d_byte, sext,
        input  ready
    );

    modport access (
        input  new_instr, valid, addr, wdata, load, store,
        input  d_double, d_word, d_half, d_byte, sext,
        output ready
    );

    // Result side only watches the access
    modport monitor (
        input valid, addr, load, d_double, d_word, d_half, d_byte, sext, ready
    );

endinterface

`default_nettype wire

/* src/lsu_issue.sv */
// Issue stage of the load/store unit
// Command handshake, effective address, opcode decode, one-access FSM

`timescale 1ns/1ns
`default_nettype none

module lsu_issue import lsu_pkg::*; (
    input  wire            g_clk,
    input  wire            g_resetn,
    input  wire            cmd_valid,
    output logic           cmd_ready,
    input  wire mem_op_e   cmd_op,
    input  wire lsu_addr_t cmd_base,
    input  wire lsu_addr_t cmd_offset,
    input  wire lsu_data_t cmd_wdata,
    lsu_req_if.issue       req
);

    issue_state_e state_q;
    issue_state_e state_d;
    logic         accept;
    logic         new_q;
    logic         dec_load;
    logic         dec_store;
    logic         dec_sext;
    logic [3:0]   dec_size;         // One-hot {double, word, half, byte}
    logic         load_q;
    logic         store_q;
    logic         sext_q;
    logic [3:0]   size_q;
    lsu_addr_t    addr_q;
    lsu_data_t    wdata_q;

    assign accept = cmd_valid && cmd_ready;

    always_comb begin
        dec_load  = 1'b0;
        dec_store = 1'b0;
        dec_sext  = 1'b0;
        dec_size  = 4'b0000;
        unique case (cmd_op)
            LB:  begin dec_load  = 1'b1; dec_sext = 1'b1; dec_size = 4'b0001; end
            LH:  begin dec_load  = 1'b1; dec_sext = 1'b1; dec_size = 4'b0010; end
            LW:  begin dec_load  = 1'b1; dec_sext = 1'b1; dec_size = 4'b0100; end
            LD:  begin dec_load  = 1'b1; dec_size = 4'b1000; end
            LBU: begin dec_load  = 1'b1; dec_size = 4'b0001; end
            LHU: begin dec_load  = 1'b1; dec_size = 4'b0010; end
            LWU: begin dec_load  = 1'b1; dec_size = 4'b0100; end
            SB:  begin dec_store = 1'b1; dec_size = 4'b0001; end
            SH:  begin dec_store = 1'b1; dec_size = 4'b0010; end
            SW:  begin dec_store = 1'b1; dec_size = 4'b0100; end
            SD:  begin dec_store = 1'b1; dec_size = 4'b1000; end
            default: dec_size = 4'b0000;    // Unused codes do nothing
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ISSUE_IDLE: if (accept) state_d = ISSUE_BUSY;
            ISSUE_BUSY: if (req.ready) state_d = ISSUE_IDLE;
            default:    state_d = ISSUE_IDLE;
        endcase
    end

    // Ready is registered so it stays low through reset
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state_q   <= ISSUE_IDLE;
            cmd_ready <= 1'b0;
            new_q     <= 1'b0;
        end else begin
            state_q   <= state_d;
            cmd_ready <= (state_d == ISSUE_IDLE);
            new_q     <= accept;        // Pulse in first busy cycle
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            addr_q  <= cmd_base + cmd_offset;
            wdata_q <= cmd_wdata;
            load_q  <= dec_load;
            store_q <= dec_store;
            sext_q  <= dec_sext;
            size_q  <= dec_size;
        end
    end

    assign req.valid     = (state_q == ISSUE_BUSY);
    assign req.new_instr = new_q;
    assign req.addr      = addr_q;
    assign req.wdata     = wdata_q;
    assign req.load      = load_q;
    assign req.store     = store_q;
    assign req.sext      = sext_q;
    assign req.d_double  = size_q[3];
    assign req.d_word    = size_q[2];
    assign req.d_half    = size_q[1];
    assign req.d_byte    = size_q[0];

endmodule

`default_nettype wire

/* src/lsu_access.sv */
// Access block of the load/store unit
// Alignment check and trap, data memory request, byte strobes
// and write data positioning on the doubleword bus

`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module lsu_access import lsu_pkg::*; (
    input  wire                    g_clk,
    input  wire                    g_resetn,
    lsu_req_if.access              req,
    output logic                   req_sent,
    output logic                   trap_addr,
    output logic                   dmem_req,
    output lsu_addr_t              dmem_addr,
    output logic                   dmem_wen,
    output logic [`LSU_STRB_W-1:0] dmem_strb,
    output lsu_data_t              dmem_wdata,
    input  wire                    dmem_gnt
);

    logic                   finished;       // Request already granted
    logic                   misaligned;
    logic [2:0]             byte_off;       // Byte lane of the access
    logic [5:0]             data_shift;     // Bit offset of that lane
    logic [`LSU_STRB_W-1:0] size_mask;
    logic [`LSU_STRB_W-1:0] strb;

    assign byte_off = req.addr[2:0];

    // Natural alignment for each access size
    assign misaligned = (req.d_double && |byte_off[2:0]) ||
                        (req.d_word   && |byte_off[1:0]) ||
                        (req.d_half   &&  byte_off[0]);

    assign trap_addr = req.valid && misaligned;

    // A new instruction overrides the flag left by the previous access
    assign dmem_req  = req.valid && !misaligned && (req.new_instr || !finished);
    assign req_sent  = dmem_req && dmem_gnt;
    assign req.ready = req_sent || trap_addr;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            finished <= 1'b0;
        end else if (req_sent) begin
            finished <= 1'b1;
        end else if (req.new_instr) begin
            finished <= 1'b0;
        end
    end

    // Bus addresses are always doubleword aligned
    assign dmem_addr = {req.addr[`LSU_ADDR_W-1:3], 3'b000};
    assign dmem_wen  = req.valid && req.store;

    assign data_shift = {byte_off, 3'b000};
    assign dmem_wdata = req.wdata << data_shift;    // Store data onto its lanes

    // Lanes covered by the access size at offset zero
    always_comb begin
        size_mask = '0;
        if (req.d_double) begin
            size_mask = 8'hff;
        end else if (req.d_word) begin
            size_mask = 8'h0f;
        end else if (req.d_half) begin
            size_mask = 8'h03;
        end else if (req.d_byte) begin
            size_mask = 8'h01;
        end
    end

    assign strb      = size_mask << byte_off;           // Aligned, so no wrap
    assign dmem_strb = (req.valid && req.store) ? strb : '0;

endmodule

`default_nettype wire

/* src/lsu_load_align.sv */
// Result side of the load/store unit
// Load data extraction and extension, trap and bus error reporting,
// one result pulse per completed access

`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module lsu_load_align import lsu_pkg::*; (
    input  wire            g_clk,
    input  wire            g_resetn,
    lsu_req_if.monitor     req,
    input  wire            req_sent,
    input  wire            trap_addr,
    input  wire            dmem_err,
    input  wire lsu_data_t dmem_rdata,
    output logic           result_valid,
    output lsu_data_t      result_data,
    output logic           result_trap,
    output logic           result_err
);

    logic      complete;            // Access finishes this cycle
    logic [5:0] rd_shift;
    lsu_data_t rd_lane;             // Addressed bytes moved to bit 0
    lsu_data_t ld_ext;

    assign complete = req.valid && req.ready;
    assign rd_shift = {req.addr[2:0], 3'b000};
    assign rd_lane  = dmem_rdata >> rd_shift;

    // Cut to access size, then extend
    always_comb begin
        ld_ext = rd_lane;               // Doubleword keeps every byte
        if (req.d_byte) begin
            ld_ext = {{(`LSU_DATA_W-8){req.sext && rd_lane[7]}}, rd_lane[7:0]};
        end else if (req.d_half) begin
            ld_ext = {{(`LSU_DATA_W-16){req.sext && rd_lane[15]}}, rd_lane[15:0]};
        end else if (req.d_word) begin
            ld_ext = {{(`LSU_DATA_W-32){req.sext && rd_lane[31]}}, rd_lane[31:0]};
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            result_valid <= 1'b0;
            result_trap  <= 1'b0;
            result_err   <= 1'b0;
        end else begin
            result_valid <= complete;   // Ready lasts one cycle
            if (complete) begin
                result_trap <= trap_addr;
                result_err  <= req_sent && dmem_err;
            end
        end
    end

    // Stores and trapped accesses return zero
    always_ff @(posedge g_clk) begin
        if (complete) begin
            result_data <= (req.load && req_sent) ? ld_ext : '0;
        end
    end

endmodule

`default_nettype wire

/* src/lsu_top.sv */
// Top level of the load/store unit
// Issue stage, access block and result side joined by one request interface

`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module lsu_top import lsu_pkg::*; (
    input  wire                    g_clk,
    input  wire                    g_resetn,
    input  wire                    cmd_valid,
    output logic                   cmd_ready,
    input  wire mem_op_e           cmd_op,
    input  wire lsu_addr_t         cmd_base,
    input  wire lsu_addr_t         cmd_offset,
    input  wire lsu_data_t         cmd_wdata,
    output logic                   result_valid,
    output lsu_data_t              result_data,
    output logic                   result_trap,
    output logic                   result_err,
    output logic                   dmem_req,
    output lsu_addr_t              dmem_addr,
    output logic                   dmem_wen,
    output logic [`LSU_STRB_W-1:0] dmem_strb,
    output lsu_data_t              dmem_wdata,
    input  wire                    dmem_gnt,
    input  wire                    dmem_err,
    input  wire lsu_data_t         dmem_rdata
);

    logic req_sent;                 // Request granted this cycle
    logic trap_addr;                // Misaligned access

    lsu_req_if u_req_if ();

    lsu_issue u_issue (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_base   (cmd_base),
        .cmd_offset (cmd_offset),
        .cmd_wdata  (cmd_wdata),
        .req        (u_req_if.issue)
    );

    lsu_access u_access (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .req        (u_req_if.access),
        .req_sent   (req_sent),
        .trap_addr  (trap_addr),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_wen   (dmem_wen),
        .dmem_strb  (dmem_strb),
        .dmem_wdata (dmem_wdata),
        .dmem_gnt   (dmem_gnt)
    );

    lsu_load_align u_load_align (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .req          (u_req_if.monitor),
        .req_sent     (req_sent),
        .trap_addr    (trap_addr),
        .dmem_err     (dmem_err),
        .dmem_rdata   (dmem_rdata),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_trap  (result_trap),
        .result_err   (result_err)
    );

endmodule

`default_nettype wire

/* tests/tb_mem_model.sv */
// Data memory responder for the load/store unit testbench
// 128 bytes, grant after a delay chosen per command,
// bus error on one doubleword address

`timescale 1ns/1ns
`default_nettype none

module tb_mem_model import lsu_pkg::*; #(
    parameter lsu_addr_t ERR_ADDR = 64'h40
) (
    input  wire            g_clk,
    input  wire            g_resetn,
    input  wire [1:0]      gnt_delay,       // Wait cycles before the grant
    input  wire            dmem_req,
    input  wire lsu_addr_t dmem_addr,
    input  wire            dmem_wen,
    input  wire [7:0]      dmem_strb,
    input  wire lsu_data_t dmem_wdata,
    output logic           dmem_gnt,
    output logic           dmem_err,
    output lsu_data_t      dmem_rdata
);

    logic [7:0] mem [0:127];
    logic [1:0] wait_cnt;
    logic [6:0] base;                       // First byte of the doubleword

    function automatic logic [7:0] fill_byte(input int i);
        return 8'((i * 29) ^ (i >> 2) ^ 32'h5a);
    endfunction

    initial begin
        for (int i = 0; i < 128; i++) begin
            mem[i] = fill_byte(i);
        end
    end

    assign base     = {dmem_addr[6:3], 3'b000};
    assign dmem_gnt = dmem_req && (wait_cnt == gnt_delay);
    assign dmem_err = dmem_gnt && (dmem_addr == ERR_ADDR);

    always_comb begin
        dmem_rdata = '0;                    // Errored reads return zero
        if (!dmem_err) begin
            for (int b = 0; b < 8; b++) begin
                dmem_rdata[{3'(b), 3'b000} +: 8] = mem[base + 7'(b)];
            end
        end
    end

    always @(posedge g_clk) begin
        if (!g_resetn || !dmem_req || dmem_gnt) begin
            wait_cnt <= 2'd0;
        end else begin
            wait_cnt <= wait_cnt + 2'd1;    // Request held without grant
        end
    end

    // Errored writes leave the memory as it was
    always @(posedge g_clk) begin
        if (dmem_gnt && dmem_wen && !dmem_err) begin
            for (int b = 0; b < 8; b++) begin
                if (dmem_strb[b]) begin
                    mem[base + 7'(b)] <= dmem_wdata[{3'(b), 3'b000} +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_lsu.sv */
// Testbench for the load/store unit
// Clock, reset, LFSR stimulus, byte reference memory
// and concurrent assertions on the memory port and the result

`timescale 1ns/1ns
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

    localparam lsu_addr_t ERR_ADDR = 64'h40;
    localparam int        N_CMDS   = 300;
    localparam int        TIMEOUT  = 64;

    logic g_clk;
    logic g_resetn;
    logic cmd_valid;
    mem_op_e cmd_op;
    lsu_addr_t cmd_base;
    lsu_addr_t cmd_offset;
    lsu_data_t cmd_wdata;
    logic [1:0] gnt_delay;
    logic cmd_ready;
    logic result_valid;
    lsu_data_t result_data;
    logic result_trap;
    logic result_err;
    logic dmem_req;
    lsu_addr_t dmem_addr;
    logic dmem_wen;
    logic [7:0] dmem_strb;
    lsu_data_t dmem_wdata;
    logic dmem_gnt;
    logic dmem_err;
    lsu_data_t dmem_rdata;

    logic [7:0] ref_mem [0:127];
    logic [31:0] lfsr = 32'h0f126c93;
    int cycle_cnt = 0;
    int grants = 0;                         // Grants since the last acceptance

    // Expected response of the command in flight
    logic in_flight;
    logic exp_trap;
    logic exp_err;
    logic exp_store;
    lsu_addr_t exp_dw;
    logic [7:0] exp_strb;
    lsu_data_t exp_mask;                    // Bits of the accessed lanes
    lsu_data_t exp_lanes;
    lsu_data_t exp_result;
    int exp_done;
    int exp_grants;

    lsu_top u_dut (.*);

    tb_mem_model #(.ERR_ADDR(ERR_ADDR)) u_mem (.*);

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;
    end

    always @(posedge g_clk) cycle_cnt <= cycle_cnt + 1;

    always @(posedge g_clk) begin
        if (cmd_valid && cmd_ready) begin
            grants <= 0;
        end else if (dmem_req && dmem_gnt) begin
            grants <= grants + 1;
        end
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};         // One step per bit
        end
    endtask

    function automatic logic [7:0] fill_byte(input int i);
        return 8'((i * 29) ^ (i >> 2) ^ 32'h5a);
    endfunction

    function automatic int op_size(input mem_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    // Memory port carries exactly the expected access
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        dmem_req |-> in_flight && dmem_addr == exp_dw && dmem_strb == exp_strb
            && dmem_wen == exp_store && (dmem_wdata & exp_mask) == exp_lanes)
        else abort_run($sformatf("ERR %0t: request addr %h strb %h wdata %h",
            $time, dmem_addr, dmem_strb, dmem_wdata));

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        $past(dmem_req && !dmem_gnt) |-> dmem_req && $stable(dmem_addr)
            && $stable(dmem_strb) && $stable(dmem_wdata))
        else abort_run($sformatf("ERR %0t: request changed before grant", $time));

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        dmem_req && !dmem_gnt |-> !cmd_ready)
        else abort_run($sformatf("ERR %0t: cmd_ready high while request waits", $time));

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        in_flight && exp_trap |-> !dmem_req)
        else abort_run($sformatf("ERR %0t: misaligned access raised dmem_req", $time));

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        result_valid |-> in_flight && cycle_cnt == exp_done && result_trap == exp_trap
            && result_err == exp_err && grants == exp_grants)
        else abort_run($sformatf("ERR %0t: result trap %b err %b grants %0d cycle %0d",
            $time, result_trap, result_err, grants, cycle_cnt));

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        result_valid && !exp_err |-> result_data == exp_result)
        else abort_run($sformatf("ERR %0t: result data %h expected %h",
            $time, result_data, exp_result));

    task automatic wait_accept();
        int n;
        n = 0;
        @(posedge g_clk);
        while (!cmd_ready) begin
            n++;
            if (n >= TIMEOUT) abort_run("Timeout: cmd_ready did not rise within 64 cycles");
            @(posedge g_clk);
        end
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        @(posedge g_clk);
        while (!result_valid) begin
            n++;
            if (n >= TIMEOUT) abort_run("Timeout: result_valid did not rise within 64 cycles");
            @(posedge g_clk);
        end
    endtask

    task automatic run_command();
        logic [63:0] r;
        mem_op_e op;
        int size;
        logic is_store;
        logic trap;
        logic err;
        logic [1:0] delay;
        logic [2:0] kb;
        logic [2:0] lane;
        logic [6:0] idx;
        lsu_addr_t base;
        lsu_addr_t offset;
        lsu_addr_t eff;
        lsu_data_t data;
        lsu_data_t raw;
        lsu_data_t res;
        logic [7:0] strb;
        lsu_data_t mask;
        lsu_data_t lanes;

        draw_bits(4, r);
        op = mem_op_e'(4'(r % 11));
        size = op_size(op);
        is_store = op inside {SB, SH, SW, SD};
        draw_bits(6, base);
        draw_bits(6, offset);
        eff = base + offset;
        draw_bits(2, r);
        if (r != 0) begin
            offset = offset - (eff & lsu_addr_t'(size - 1));  // Align three in four
            eff = base + offset;
        end
        draw_bits(64, data);
        draw_bits(2, r);
        delay = r[1:0];
        trap = (eff & lsu_addr_t'(size - 1)) != 0;
        err = !trap && ({eff[63:3], 3'b000} == ERR_ADDR);
        strb = '0;
        mask = '0;
        lanes = '0;
        raw = '0;
        for (int k = 0; k < size; k++) begin
            kb = 3'(k);
            idx = eff[6:0] + 7'(k);
            lane = eff[2:0] + kb;
            raw[{kb, 3'b000} +: 8] = ref_mem[idx];
            if (is_store && !trap) begin
                strb[lane] = 1'b1;
                mask[{lane, 3'b000} +: 8] = 8'hff;
                lanes[{lane, 3'b000} +: 8] = data[{kb, 3'b000} +: 8];
            end
        end
        case (op)
            LB:      res = {{56{raw[7]}}, raw[7:0]};
            LH:      res = {{48{raw[15]}}, raw[15:0]};
            LW:      res = {{32{raw[31]}}, raw[31:0]};
            default: res = raw;             // Upper bytes already zero
        endcase
        if (is_store || trap) res = '0;

        cmd_valid <= 1'b1;
        cmd_op <= op;
        cmd_base <= base;
        cmd_offset <= offset;
        cmd_wdata <= data;
        gnt_delay <= delay;
        wait_accept();
        cmd_valid <= 1'b0;
        in_flight <= 1'b1;
        exp_trap <= trap;
        exp_err <= err;
        exp_store <= is_store;
        exp_dw <= {eff[63:3], 3'b000};
        exp_strb <= strb;
        exp_mask <= mask;
        exp_lanes <= lanes;
        exp_result <= res;
        exp_grants <= trap ? 0 : 1;
        exp_done <= cycle_cnt + 2 + (trap ? 0 : int'(delay));
        wait_result();
        in_flight <= 1'b0;
        if (is_store && !trap && !err) begin
            for (int k = 0; k < size; k++) begin
                kb = 3'(k);
                idx = eff[6:0] + 7'(k);
                ref_mem[idx] = data[{kb, 3'b000} +: 8];
            end
        end
    endtask

    initial begin
        g_resetn = 1'b0;
        cmd_valid = 1'b0;
        cmd_op = LB;
        cmd_base = '0;
        cmd_offset = '0;
        cmd_wdata = '0;
        gnt_delay = 2'd0;
        in_flight = 1'b0;
        exp_trap = 1'b0;
        exp_err = 1'b0;
        exp_store = 1'b0;
        exp_dw = '0;
        exp_strb = '0;
        exp_mask = '0;
        exp_lanes = '0;
        exp_result = '0;
        exp_done = 0;
        exp_grants = 0;
        for (int i = 0; i < 128; i++) begin
            ref_mem[i] = fill_byte(i);
        end
        repeat (16) @(posedge g_clk);
        assert (!cmd_ready && !result_valid)
            else abort_run($sformatf("ERR %0t: cmd_ready or result_valid high in reset", $time));
        g_resetn <= 1'b1;
        repeat (2) @(posedge g_clk);
        assert (cmd_ready && !dmem_req && !result_valid)
            else abort_run($sformatf("ERR %0t: wrong idle outputs after reset", $time));
        for (int n = 0; n < N_CMDS; n++) begin
            run_command();
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/lsu_pkg.sv
src/lsu_req_if.sv
src/lsu_issue.sv
src/lsu_access.sv
src/lsu_load_align.sv
src/lsu_top.sv
tests/tb_mem_model.sv
tests/tb_lsu.sv

/* Makefile */
# Verilator build and run of the load/store unit testbench
# A failing check ends the run through $fatal, so make sees the error status

sim:
	verilator --binary --assert -j 0 --top-module tb_lsu -Mdir obj_dir -f all.f
	./obj_dir/Vtb_lsu

clean:
	rm -rf obj_dir

.PHONY: sim clean
